// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_com_reply
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_TEXT  ?= STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/tb_com_reply.sv
`timescale 1ns/1ps

module tb_com_reply;
    import com_pkg::*;

    localparam int RST_CYCLES = 16;
    localparam int RAM_WORDS  = 65536;
    localparam int MAX_LEN    = 4104;          // Header, trigger and eight 512-word channels.
    localparam int LIMIT_NS   = 8 * (RAM_WORDS + RST_CYCLES + 20 * (MAX_LEN + 100));

    logic        clk;
    logic        rst;
    logic        fs_send;
    send_req_t   req;
    logic        fd_send;
    ram_wr_t     ram_wr;
    tx_beat_t    tx;

    int          seed;
    int          errors;
    int          tests_passed;
    int          tests_failed;
    int          last_len;                     // Length a non-data request repeats.
    logic [15:0] slot_base [6];

    com_reply_top i_dut (
        .clk     (clk),
        .rst     (rst),
        .fs_send (fs_send),
        .req     (req),
        .fd_send (fd_send),
        .ram_wr  (ram_wr),
        .tx      (tx)
    );

    initial begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;

    initial begin
        #LIMIT_NS;
        $display("ERROR: run timed out after %0d ns", LIMIT_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    function automatic int code_words(input logic [1:0] code);
        case (code)
            2'd1:    return 128;
            2'd2:    return 256;
            2'd3:    return 512;
            default: return 0;
        endcase
    endfunction

    function automatic int data_words(input logic [15:0] codes);
        int total;
        total = 8;                             // Header and trigger words.
        for (int ch = 0; ch < 8; ch++) begin
            total = total + code_words(codes[2*ch +: 2]);
        end
        return total;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic report_mismatch(input string sig, input int exp, input int act);
        $display("[FAIL] t=%0t %s expected 0x%0h actual 0x%0h", $time, sig, exp, act);
        errors++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR: t=%0t %s", $time, msg);
        errors++;
    endtask

    task automatic close_test(input string name, input int err_before);
        if (errors == err_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_before);
        end
    endtask

    task automatic preload_ram();
        for (int a = 0; a < RAM_WORDS; a++) begin
            ram_wr.en   = 1'b1;
            ram_wr.addr = a[15:0];
            ram_wr.data = a[15:0] ^ 16'h5A5A;
            step();
        end
        ram_wr = '0;
    endtask

    task automatic run_reply(input logic [3:0] btype, input logic [3:0] idx,
                             input logic [15:0] codes, input logic [15:0] exp_addr,
                             input int exp_len, input int hold_cycles);
        int          count;
        int          waited;
        logic        seen_last;
        logic [15:0] addr;
        count     = 0;
        waited    = 0;
        seen_last = 1'b0;
        addr      = exp_addr;
        req.btype                  = btype;
        req.data_idx               = idx;
        req.cache_info.rsvd        = $random(seed);
        req.cache_info.device_type = codes;
        req.cache_info.cache_state = {$random(seed), $random(seed)};
        fs_send = 1'b1;
        while (!seen_last && !fd_send && waited < exp_len + 50) begin
            step();
            waited++;
            if (tx.valid) begin
                if (tx.data !== (addr ^ 16'h5A5A)) begin
                    report_mismatch("tx.data", addr ^ 16'h5A5A, tx.data);
                end
                if (tx.last !== (count == exp_len - 1)) begin
                    report_mismatch("tx.last", count == exp_len - 1, tx.last);
                end
                seen_last = tx.last;
                count++;
                addr = addr + 16'd1;           // Wraps like the RAM address.
            end else if (count > 0) begin
                report_error("gap in the tx stream before the last word");
            end
        end
        if (!seen_last && !fd_send) begin
            report_error("reply stream did not end in time");
        end
        if (count != exp_len) begin
            report_mismatch("word count", exp_len, count);
        end
        waited = 0;
        while (!fd_send && waited < 20) begin
            step();
            waited++;
            if (tx.valid) begin
                report_error("tx.valid high after the last word");
            end
        end
        if (!fd_send) begin
            report_error("fd_send did not rise after the reply");
        end
        for (int i = 0; i < hold_cycles; i++) begin
            step();
            if (fd_send !== 1'b1) begin
                report_mismatch("fd_send", 1, fd_send);
            end
        end
        fs_send = 1'b0;
        step();
        if (fd_send !== 1'b0) begin
            report_mismatch("fd_send", 0, fd_send);
        end
    endtask

    task automatic idle_after_reset();
        int err_before;
        err_before = errors;
        for (int i = 0; i < 20; i++) begin
            step();
            if (fd_send !== 1'b0) begin
                report_mismatch("fd_send", 0, fd_send);
            end
            if (tx.valid !== 1'b0) begin
                report_mismatch("tx.valid", 0, tx.valid);
            end
        end
        close_test("idle_after_reset", err_before);
    endtask

    task automatic status_reply();
        int err_before;
        err_before = errors;
        run_reply(4'hA, 4'd0, $random(seed), 16'h2300, 14, 0);
        last_len = 14;
        close_test("status_reply", err_before);
    endtask

    task automatic conf_after_status();
        int err_before;
        err_before = errors;
        run_reply(4'h1, 4'd3, $random(seed), 16'hF000, last_len, 0);
        close_test("conf_after_status", err_before);
    endtask

    task automatic data_slot_replies();
        int          err_before;
        logic [15:0] codes;
        err_before = errors;
        for (int s = 0; s < 6; s++) begin
            codes = $random(seed);
            run_reply(4'h5, s[3:0], codes, slot_base[s], data_words(codes), 0);
            last_len = data_words(codes);
        end
        run_reply(4'h5, 4'd0, 16'h0000, slot_base[0], 8, 0);
        last_len = 8;
        close_test("data_slot_replies", err_before);
    endtask

    task automatic unmapped_slot_replies();
        int          err_before;
        logic [15:0] codes;
        logic [3:0]  idx_list [3];
        err_before  = errors;
        idx_list[0] = 4'd6;
        idx_list[1] = 4'd11;
        idx_list[2] = 4'd15;
        for (int k = 0; k < 3; k++) begin
            codes = $random(seed);
            run_reply(4'h5, idx_list[k], codes, 16'hF000, data_words(codes), 0);
        end
        run_reply(4'h5, 4'd7, 16'hFFFF, 16'hF000, MAX_LEN, 0);   // Runs past 16'hFFFF.
        last_len = MAX_LEN;
        close_test("unmapped_slot_replies", err_before);
    endtask

    task automatic held_request();
        int          err_before;
        logic [15:0] codes;
        err_before = errors;
        run_reply(4'hA, 4'd0, $random(seed), 16'h2300, 14, 10);
        codes = $random(seed);
        run_reply(4'h5, 4'd2, codes, slot_base[2], data_words(codes), 0);
        close_test("held_request", err_before);
    endtask

    initial begin
        seed         = 32'hc181_b926;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        last_len     = 0;
        slot_base[0] = 16'h0000;
        slot_base[1] = 16'h2400;
        slot_base[2] = 16'h4800;
        slot_base[3] = 16'h6C00;
        slot_base[4] = 16'h9000;
        slot_base[5] = 16'hB400;
        rst          = 1'b1;
        fs_send      = 1'b0;
        req          = '0;
        ram_wr       = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        preload_ram();
        idle_after_reset();
        status_reply();
        conf_after_status();
        data_slot_replies();
        unmapped_slot_replies();
        held_request();
        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: src/com_pkg.sv
package com_pkg;

    // Command types.
    localparam logic [3:0] COM_INIT = 4'h0;
    localparam logic [3:0] COM_CONF = 4'h1;
    localparam logic [3:0] COM_READ = 4'h4;
    localparam logic [3:0] COM_DATA = 4'h5;
    localparam logic [3:0] COM_STOP = 4'h9;
    localparam logic [3:0] COM_STAT = 4'hA;

    localparam int RAM_AW     = 16;
    localparam int RAM_DW     = 16;
    localparam int CH_NUM     = 8;     // Channels per device-type word.
    localparam int DATA_SLOTS = 6;

    // Reply lengths in words.
    localparam logic [15:0] STAT_LEN    = 16'd14;
    localparam logic [15:0] HEAD_LEN    = 16'd4;
    localparam logic [15:0] TRGG_LEN    = 16'd4;
    localparam logic [15:0] DATA_LEN_00 = 16'd0;
    localparam logic [15:0] DATA_LEN_01 = 16'd128;
    localparam logic [15:0] DATA_LEN_10 = 16'd256;
    localparam logic [15:0] DATA_LEN_11 = 16'd512;

    // Reply RAM map.
    localparam logic [RAM_AW-1:0] COM_RAM_ADDR_DATA0 = 16'h0000;
    localparam logic [RAM_AW-1:0] COM_RAM_ADDR_DATA1 = 16'h2400;
    localparam logic [RAM_AW-1:0] COM_RAM_ADDR_DATA2 = 16'h4800;
    localparam logic [RAM_AW-1:0] COM_RAM_ADDR_DATA3 = 16'h6C00;
    localparam logic [RAM_AW-1:0] COM_RAM_ADDR_DATA4 = 16'h9000;
    localparam logic [RAM_AW-1:0] COM_RAM_ADDR_DATA5 = 16'hB400;
    localparam logic [RAM_AW-1:0] COM_RAM_ADDR_STAT  = 16'h2300;
    localparam logic [RAM_AW-1:0] COM_RAM_ADDR_INIT  = 16'hF000;

    localparam logic [RAM_AW-1:0] DATA_BASE [DATA_SLOTS] = '{
        COM_RAM_ADDR_DATA0, COM_RAM_ADDR_DATA1, COM_RAM_ADDR_DATA2,
        COM_RAM_ADDR_DATA3, COM_RAM_ADDR_DATA4, COM_RAM_ADDR_DATA5
    };

    // Request FSM, one-hot.
    localparam logic [5:0] ST_IDLE = 6'b00_0001;
    localparam logic [5:0] ST_WAIT = 6'b00_0010;
    localparam logic [5:0] ST_CAL0 = 6'b00_0100;
    localparam logic [5:0] ST_CAL1 = 6'b00_1000;
    localparam logic [5:0] ST_WORK = 6'b01_0000;
    localparam logic [5:0] ST_DONE = 6'b10_0000;

    // Word sender FSM.
    localparam logic [1:0] ES_IDLE  = 2'd0;
    localparam logic [1:0] ES_READ  = 2'd1;
    localparam logic [1:0] ES_DRAIN = 2'd2;
    localparam logic [1:0] ES_DONE  = 2'd3;

    typedef logic [0:CH_NUM-1][1:0] dev_type_t;   // Channel 0 in the top pair.

    typedef struct packed {
        logic [15:0] rsvd;
        dev_type_t   device_type;                 // Bits 79:64.
        logic [63:0] cache_state;
    } cache_info_t;

    typedef struct packed {
        logic [3:0]  btype;
        logic [3:0]  data_idx;
        cache_info_t cache_info;
    } send_req_t;

    typedef struct packed {
        logic              en;
        logic [RAM_AW-1:0] addr;
        logic [RAM_DW-1:0] data;
    } ram_wr_t;

    typedef struct packed {
        logic              valid;
        logic              last;
        logic [RAM_DW-1:0] data;
    } tx_beat_t;

endpackage

// File: src/com_reply_top.sv
`timescale 1ns/1ps

module com_reply_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               fs_send,
    input  com_pkg::send_req_t req,
    output logic               fd_send,
    input  com_pkg::ram_wr_t   ram_wr,
    output com_pkg::tx_beat_t  tx
);
    import com_pkg::*;

    logic              fs_eth_send;
    logic              fd_eth_send;
    logic [RAM_AW-1:0] ram_rxa_init;
    logic [15:0]       ram_dlen;
    logic [RAM_AW-1:0] rd_addr;
    logic [RAM_DW-1:0] rd_data;

    com_send i_com_send (
        .clk          (clk),
        .rst          (rst),
        .fs_send      (fs_send),
        .fd_send      (fd_send),
        .fs_eth_send  (fs_eth_send),
        .fd_eth_send  (fd_eth_send),
        .req          (req),
        .ram_rxa_init (ram_rxa_init),
        .ram_dlen     (ram_dlen)
    );

    reply_ram i_reply_ram (
        .clk     (clk),
        .wr      (ram_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    eth_send i_eth_send (
        .clk          (clk),
        .rst          (rst),
        .fs_eth_send  (fs_eth_send),
        .fd_eth_send  (fd_eth_send),
        .ram_rxa_init (ram_rxa_init),
        .ram_dlen     (ram_dlen),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .tx           (tx)
    );

endmodule

// File: src/com_send.sv
`timescale 1ns/1ps

module com_send (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       fs_send,
    output logic                       fd_send,
    output logic                       fs_eth_send,
    input  logic                       fd_eth_send,
    input  com_pkg::send_req_t         req,
    output logic [com_pkg::RAM_AW-1:0] ram_rxa_init,
    output logic [15:0]                ram_dlen
);
    import com_pkg::*;

    logic [5:0]              state;
    logic [5:0]              next_state;
    logic [CH_NUM-1:0][15:0] ch_len;
    logic [15:0]             len_sum;
    dev_type_t               dev_type;

    function automatic logic [15:0] code_len(input logic [1:0] code);
        case (code)
            2'b01:   return DATA_LEN_01;
            2'b10:   return DATA_LEN_10;
            2'b11:   return DATA_LEN_11;
            default: return DATA_LEN_00;
        endcase
    endfunction

    assign dev_type    = req.cache_info.device_type;
    assign fs_eth_send = (state == ST_WORK);
    assign fd_send     = (state == ST_DONE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        case (state)
            ST_IDLE: next_state = ST_WAIT;
            ST_WAIT: next_state = fs_send ? ST_CAL0 : ST_WAIT;
            ST_CAL0: next_state = ST_CAL1;
            ST_CAL1: next_state = ST_WORK;
            ST_WORK: next_state = fd_eth_send ? ST_DONE : ST_WORK;
            ST_DONE: next_state = fs_send ? ST_DONE : ST_WAIT;   // Host must drop the request.
            default: next_state = ST_IDLE;
        endcase
    end

    // Per-channel payload size, decoded from the two-bit codes.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ch_len <= '0;
        end else if (state == ST_IDLE) begin
            ch_len <= '0;
        end else if (state == ST_CAL0) begin
            for (int i = 0; i < CH_NUM; i++) begin
                ch_len[i] <= code_len(dev_type[i]);
            end
        end
    end

    always_comb begin
        len_sum = HEAD_LEN + TRGG_LEN;
        for (int i = 0; i < CH_NUM; i++) begin
            len_sum = len_sum + ch_len[i];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ram_rxa_init <= COM_RAM_ADDR_INIT;
            ram_dlen     <= '0;
        end else if (state == ST_IDLE) begin
            ram_dlen <= '0;
        end else if (state == ST_CAL1) begin
            case (req.btype)
                COM_STAT: begin
                    ram_rxa_init <= COM_RAM_ADDR_STAT;
                    ram_dlen     <= STAT_LEN;
                end
                COM_DATA: begin
                    ram_dlen <= len_sum;
                    if (req.data_idx < DATA_SLOTS) begin
                        ram_rxa_init <= DATA_BASE[req.data_idx[2:0]];
                    end else begin
                        ram_rxa_init <= COM_RAM_ADDR_INIT;   // No such slot.
                    end
                end
                default: begin
                    ram_rxa_init <= COM_RAM_ADDR_INIT;   // Length left as it was.
                end
            endcase
        end
    end

    a_send_done_excl: assert property (
        @(posedge clk) disable iff (rst) !(fs_eth_send && fd_send)
    ) else $error("fs_eth_send and fd_send high together");

endmodule

// File: src/eth_send.sv
`timescale 1ns/1ps

module eth_send (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       fs_eth_send,
    output logic                       fd_eth_send,
    input  logic [com_pkg::RAM_AW-1:0] ram_rxa_init,
    input  logic [15:0]                ram_dlen,
    output logic [com_pkg::RAM_AW-1:0] rd_addr,
    input  logic [com_pkg::RAM_DW-1:0] rd_data,
    output com_pkg::tx_beat_t          tx
);
    import com_pkg::*;

    logic [1:0]        state;
    logic [RAM_AW-1:0] addr_cnt;
    logic [15:0]       remain;       // Reads still to issue.
    logic              pend_valid;
    logic              pend_last;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= ES_IDLE;
            addr_cnt   <= '0;
            remain     <= '0;
            pend_valid <= 1'b0;
            pend_last  <= 1'b0;
        end else begin
            pend_valid <= 1'b0;
            pend_last  <= 1'b0;
            case (state)
                ES_IDLE: begin
                    if (fs_eth_send) begin
                        addr_cnt <= ram_rxa_init;
                        remain   <= ram_dlen;
                        state    <= (ram_dlen == 16'd0) ? ES_DRAIN : ES_READ;
                    end
                end
                ES_READ: begin
                    // Flags line up with the word the RAM returns next cycle.
                    pend_valid <= 1'b1;
                    pend_last  <= (remain == 16'd1);
                    addr_cnt   <= addr_cnt + 1'b1;   // Wraps at the top of the RAM.
                    remain     <= remain - 1'b1;
                    if (remain == 16'd1) begin
                        state <= ES_DRAIN;
                    end
                end
                ES_DRAIN: begin
                    state <= ES_DONE;
                end
                ES_DONE: begin
                    if (!fs_eth_send) begin
                        state <= ES_IDLE;
                    end
                end
                default: begin
                    state <= ES_IDLE;
                end
            endcase
        end
    end

    assign rd_addr     = addr_cnt;
    assign fd_eth_send = (state == ES_DONE);

    assign tx = '{valid: pend_valid, last: pend_last, data: rd_data};

    // The stream must be finished before the request is released.
    a_valid_in_send: assert property (
        @(posedge clk) disable iff (rst) tx.valid |-> fs_eth_send
    ) else $error("tx.valid outside fs_eth_send");

endmodule

// File: src/reply_ram.sv
`timescale 1ns/1ps

module reply_ram (
    input  logic                       clk,
    input  com_pkg::ram_wr_t           wr,
    input  logic [com_pkg::RAM_AW-1:0] rd_addr,
    output logic [com_pkg::RAM_DW-1:0] rd_data
);
    import com_pkg::*;

    logic [RAM_DW-1:0] mem [2**RAM_AW];

    // Host side.
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Sender side, one cycle of read latency.
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: tb.f
src/com_pkg.sv
src/com_send.sv
src/reply_ram.sv
src/eth_send.sv
src/com_reply_top.sv
bench/tb_com_reply.sv
